// File: src/synth_params.svh
// Build constants for the MIDI tone generator
// SYN_BAUD_DIV is scaled down for simulation; use 3200 on real hardware
// SYN_BCLK_DIV must stay at 2 or above so BCLK has a full high and low phase
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// UART bit period in iCLK cycles
`define SYN_BAUD_DIV 16

// BCLK half period in iCLK cycles
`define SYN_BCLK_DIV 2

// Audio word width on the I2S line
`define SYN_SAMPLE_W 16

// Velocity to amplitude scaling
`define SYN_AMP_SHIFT 8

// Half period of the lowest tone, in samples
`define SYN_TONE_BASE 2

`endif

// File: src/synthPkg.sv
// Shared types for the tone generator
// Sample width follows SYN_SAMPLE_W from the params header
`include "synth_params.svh"

package synthPkg;

	//------------------------------------------------------------
	// Parser
	//------------------------------------------------------------
	typedef enum logic [1:0]
	{
		IDLE      = 2'd0,
		WAIT_NOTE = 2'd1,
		WAIT_VEL  = 2'd2
	} parseStateT;

	//------------------------------------------------------------
	// Note event fields
	//------------------------------------------------------------
	// MIDI data bytes carry 7 bits
	typedef logic [6:0] noteNumT;
	typedef logic [6:0] velocityT;

	// Two's complement audio sample
	typedef logic signed [`SYN_SAMPLE_W-1:0] sampleT;

endpackage

// File: src/noteIf.sv
// Note event from parser to oscillator
// Fields are only meaningful in the cycle evt is high, no back-pressure
`timescale 1ns/10ps

interface noteIf import synthPkg::*; ();

	// One-cycle event strobe
	logic     evt;
	// High for note-on, low for note-off
	logic     gateOn;
	noteNumT  note;
	velocityT velocity;

	// Parser side
	modport src (output evt, output gateOn, output note, output velocity);

	// Oscillator side
	modport dst (input evt, input gateOn, input note, input velocity);

endinterface

// File: src/bitTimer.sv
// Free-running tick divider
// divide must be 2 or more; restart puts the next tick half a period away
`timescale 1ns/10ps

module bitTimer #(
	parameter int divide = 16
)(
	input  logic iCLK,
	input  logic rstN,
	input  logic restart,
	output logic tick
);

	localparam int cntW = (divide > 2) ? $clog2(divide) : 1;

	logic [cntW-1:0] cnt;

	// Down counter, tick issued the cycle after it hits zero
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			cnt  <= cntW'(divide - 1);
			tick <= 1'b0;
		end
		else if (restart)
		begin
			// Half period, used for mid-bit sampling
			cnt  <= cntW'(divide / 2 - 1);
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt  <= cntW'(divide - 1);
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

	// Tick is a strobe, never a level
	assert property (@(posedge iCLK) disable iff (!rstN) tick |=> !tick);

endmodule

// File: src/midiRx.sv
// MIDI UART receiver, 8N1, LSB first
// Relies on baudTick from an external bitTimer restarted by baudSync
// Bytes with a low stop bit are dropped silently
`timescale 1ns/10ps

module midiRx (
	input  logic       iCLK,
	input  logic       rstN,
	input  logic       iMIDI,
	input  logic       baudTick,
	output logic       baudSync,
	output logic [7:0] rxByte,
	output logic       rxValid
);

	logic [1:0] midiSync;
	logic       midiPrev;
	logic       rxIn;
	logic       startEdge;
	logic       busy;
	logic [3:0] bitCnt;
	logic [7:0] shiftReg;
	logic       byteDone;

	//------------------------------------------------------------
	// Input sync and start edge
	//------------------------------------------------------------
	assign rxIn      = midiSync[1];
	assign startEdge = midiPrev && !rxIn;
	// Realign the bit timer on the start bit edge
	assign baudSync  = startEdge && !busy;

	// Bit 0 is start, 1..8 data, 9 stop
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			// Idle line is high
			midiSync <= 2'b11;
			midiPrev <= 1'b1;
			busy     <= 1'b0;
			bitCnt   <= 4'd0;
			rxValid  <= 1'b0;
		end
		else
		begin
			midiSync <= {midiSync[0], iMIDI};
			midiPrev <= rxIn;
			rxValid  <= 1'b0;
			if (baudSync)
			begin
				busy   <= 1'b1;
				bitCnt <= 4'd0;
			end
			else if (busy && baudTick)
			begin
				bitCnt <= bitCnt + 4'd1;
				// Glitch on the start bit, back to idle
				if (bitCnt == 4'd0 && rxIn)
					busy <= 1'b0;
				if (bitCnt == 4'd9)
				begin
					busy    <= 1'b0;
					rxValid <= rxIn;
				end
			end
		end
	end

	//------------------------------------------------------------
	// Data path
	//------------------------------------------------------------
	assign byteDone = busy && baudTick && (bitCnt == 4'd9) && rxIn;

	always_ff @(posedge iCLK)
	begin
		// LSB arrives first, shift right
		if (busy && baudTick && bitCnt >= 4'd1 && bitCnt <= 4'd8)
			shiftReg <= {rxIn, shiftReg[7:1]};
		if (byteDone)
			rxByte <= shiftReg;
	end

	assert property (@(posedge iCLK) disable iff (!rstN) rxValid |=> !rxValid);

endmodule

// File: src/midiParser.sv
// Note-on / note-off parser, omni mode
// No running status; system and controller messages fall back to IDLE
`timescale 1ns/10ps

module midiParser import synthPkg::*; (
	input  logic       iCLK,
	input  logic       rstN,
	input  logic [7:0] rxByte,
	input  logic       rxValid,
	noteIf.src         ev
);

	parseStateT state;
	noteNumT    noteReg;
	logic       isNoteOn;
	logic       isStatus;
	logic       isNoteMsg;

	assign isStatus  = rxByte[7];
	// 8x note-off, 9x note-on, channel nibble ignored
	assign isNoteMsg = (rxByte[7:4] == 4'h8) || (rxByte[7:4] == 4'h9);

	//------------------------------------------------------------
	// Message FSM
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			state  <= IDLE;
			ev.evt <= 1'b0;
		end
		else
		begin
			ev.evt <= 1'b0;
			if (rxValid)
			begin
				// Status byte always restarts parsing
				if (isStatus)
					state <= isNoteMsg ? WAIT_NOTE : IDLE;
				else
				begin
					case (state)
						WAIT_NOTE: state <= WAIT_VEL;
						WAIT_VEL:
						begin
							state  <= IDLE;
							ev.evt <= 1'b1;
						end
						default: state <= IDLE;
					endcase
				end
			end
		end
	end

	// Message fields
	always_ff @(posedge iCLK)
	begin
		if (rxValid && isStatus && isNoteMsg)
			isNoteOn <= rxByte[4];
		if (rxValid && !isStatus && state == WAIT_NOTE)
			noteReg <= rxByte[6:0];
		if (rxValid && !isStatus && state == WAIT_VEL)
		begin
			ev.note     <= noteReg;
			ev.velocity <= rxByte[6:0];
			// Velocity 0 on 9x is a note-off
			ev.gateOn   <= isNoteOn && (rxByte[6:0] != 7'd0);
		end
	end

	assert property (@(posedge iCLK) disable iff (!rstN)
		state inside {IDLE, WAIT_NOTE, WAIT_VEL});

endmodule

// File: src/toneOsc.sv
// Monophonic square-wave oscillator
// Half period is (note + SYN_TONE_BASE) samples; output is silent with gate off
`timescale 1ns/10ps
`include "synth_params.svh"

module toneOsc import synthPkg::*; (
	input  logic iCLK,
	input  logic rstN,
	noteIf.dst   ev,
	input  logic sampleReq,
	output sampleT sample
);

	logic     gate;
	logic     polarity;
	noteNumT  heldNote;
	velocityT heldVel;
	logic [7:0] halfCnt;
	logic [7:0] halfLimit;
	sampleT   amp;

	assign halfLimit = {1'b0, heldNote} + 8'(`SYN_TONE_BASE);
	assign amp       = sampleT'(heldVel) <<< `SYN_AMP_SHIFT;

	//------------------------------------------------------------
	// Note state
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
			gate <= 1'b0;
		else if (ev.evt)
		begin
			if (ev.gateOn)
				gate <= 1'b1;
			// Only the held note can release the gate
			else if (ev.note == heldNote)
				gate <= 1'b0;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (ev.evt && ev.gateOn)
		begin
			heldNote <= ev.note;
			heldVel  <= ev.velocity;
		end
	end

	//------------------------------------------------------------
	// Waveform, one step per sample request
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			halfCnt  <= 8'd0;
			polarity <= 1'b0;
			sample   <= '0;
		end
		else if (sampleReq)
		begin
			// >= covers a switch to a shorter period mid-cycle
			if (halfCnt >= halfLimit - 8'd1)
			begin
				halfCnt  <= 8'd0;
				polarity <= !polarity;
			end
			else
				halfCnt <= halfCnt + 8'd1;
			if (!gate)
				sample <= '0;
			else
				sample <= polarity ? -amp : amp;
		end
	end

endmodule

// File: src/i2sTx.sv
// I2S transmitter, 32 BCLK per frame, 16-bit left then right slot
// Same sample goes out in both slots; MSB lags LRCLK by one BCLK
`timescale 1ns/10ps

module i2sTx import synthPkg::*; (
	input  logic   iCLK,
	input  logic   rstN,
	input  logic   bclkTick,
	input  sampleT sample,
	output logic   sampleReq,
	output logic   oI2S_BCLK,
	output logic   oI2S_LRCLK,
	output logic   oI2S_SDATA
);

	logic       bclk;
	logic       lrclk;
	logic       sdata;
	logic       fallEdge;
	logic [4:0] bitCnt;
	logic [4:0] nextCnt;
	logic [3:0] dataIdx;
	sampleT     frameSample;

	// Everything moves on the falling BCLK edge
	assign fallEdge = bclkTick && bclk;
	assign nextCnt  = bitCnt + 5'd1;
	// One-bit delay, wraps so slot position 0 carries the previous LSB
	assign dataIdx  = nextCnt[3:0] - 4'd1;

	//------------------------------------------------------------
	// Frame counter and serialiser
	//------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (!rstN)
		begin
			bclk        <= 1'b0;
			lrclk       <= 1'b0;
			sdata       <= 1'b0;
			bitCnt      <= 5'd31;
			sampleReq   <= 1'b0;
			frameSample <= '0;
		end
		else
		begin
			sampleReq <= 1'b0;
			if (bclkTick)
				bclk <= !bclk;
			if (fallEdge)
			begin
				bitCnt <= nextCnt;
				// Low half of the frame is the left slot
				lrclk  <= nextCnt[4];
				sdata  <= frameSample[4'd15 - dataIdx];
				if (nextCnt == 5'd0)
				begin
					frameSample <= sample;
					sampleReq   <= 1'b1;
				end
			end
		end
	end

	assign oI2S_BCLK  = bclk;
	assign oI2S_LRCLK = lrclk;
	assign oI2S_SDATA = sdata;

	// Sample requests only at the left slot start
	assert property (@(posedge iCLK) disable iff (!rstN)
		sampleReq |-> (bitCnt == 5'd0) && !lrclk && !bclk);

endmodule

// File: src/synthBlock.sv
// MIDI tone generator top, single clock domain
// Byte stream is exported on oMidiRd / oMidiVd for debug
`timescale 1ns/10ps
`include "synth_params.svh"

module synthBlock import synthPkg::*; (
	input  logic       iCLK,
	input  logic       rstN,
	input  logic       iMIDI,
	output logic       oI2S_BCLK,
	output logic       oI2S_LRCLK,
	output logic       oI2S_SDATA,
	output logic [7:0] oMidiRd,
	output logic       oMidiVd
);

	logic       baudTick;
	logic       baudSync;
	logic       bclkTick;
	logic [7:0] rxByte;
	logic       rxValid;
	logic       sampleReq;
	sampleT     sample;

	noteIf noteEv ();

	//------------------------------------------------------------
	// MIDI receive and parse
	//------------------------------------------------------------
	bitTimer #(.divide(`SYN_BAUD_DIV)) baudTimer (
		.iCLK(iCLK), .rstN(rstN), .restart(baudSync), .tick(baudTick)
	);

	midiRx midiRx_inst (
		.iCLK(iCLK), .rstN(rstN), .iMIDI(iMIDI),
		.baudTick(baudTick), .baudSync(baudSync),
		.rxByte(rxByte), .rxValid(rxValid)
	);

	assign oMidiRd = rxByte;
	assign oMidiVd = rxValid;

	midiParser midiParser_inst (
		.iCLK(iCLK), .rstN(rstN), .rxByte(rxByte), .rxValid(rxValid), .ev(noteEv)
	);

	//------------------------------------------------------------
	// Tone and I2S output
	//------------------------------------------------------------
	toneOsc toneOsc_inst (
		.iCLK(iCLK), .rstN(rstN), .ev(noteEv), .sampleReq(sampleReq), .sample(sample)
	);

	// BCLK runs free
	bitTimer #(.divide(`SYN_BCLK_DIV)) bclkTimer (
		.iCLK(iCLK), .rstN(rstN), .restart(1'b0), .tick(bclkTick)
	);

	i2sTx i2sTx_inst (
		.iCLK(iCLK), .rstN(rstN), .bclkTick(bclkTick),
		.sample(sample), .sampleReq(sampleReq),
		.oI2S_BCLK(oI2S_BCLK), .oI2S_LRCLK(oI2S_LRCLK), .oI2S_SDATA(oI2S_SDATA)
	);

endmodule

// File: testbench/tbSynth.sv
// Testbench for the MIDI tone generator top level
// Note numbers are kept small so each tone flips sign within a few frames
// Left words are rebuilt on rising BCLK, right words are compared against them
`timescale 1ns/10ps
`include "synth_params.svh"

module tbSynth import synthPkg::*; ();

	localparam int numEntries     = 8;
	localparam int noteMax        = 7;
	localparam int clkPeriod      = 40;
	localparam int driveDelay     = 2;
	localparam int frameCycles    = 64 * `SYN_BCLK_DIV;
	// Two skipped frames, then the longest sign-change window
	localparam int framesPerEntry = 3 + 2 * (noteMax + 3);
	localparam int watchdogCycles = 10 + numEntries * 3 * 10 * `SYN_BAUD_DIV
		+ (numEntries + 1) * framesPerEntry * frameCycles + 4000;

	logic       iCLK;
	logic       rstN;
	logic       iMIDI;
	logic       oI2S_BCLK;
	logic       oI2S_LRCLK;
	logic       oI2S_SDATA;
	logic [7:0] oMidiRd;
	logic       oMidiVd;

	// Stimulus table
	logic [7:0] tabStatus [numEntries];
	noteNumT    tabNote   [numEntries];
	velocityT   tabVel    [numEntries];
	int         tabAmp    [numEntries];

	logic [7:0]  rxQ[$];
	logic [15:0] shiftIn     = '0;
	logic        lrPrev      = 1'b0;
	sampleT      leftWord    = '0;
	int          frameCnt    = 0;
	int          stereoErrs  = 0;
	int          errCount    = 0;
	int          testsFailed = 0;

	synthBlock synthBlock_inst (
		.iCLK(iCLK), .rstN(rstN), .iMIDI(iMIDI),
		.oI2S_BCLK(oI2S_BCLK), .oI2S_LRCLK(oI2S_LRCLK), .oI2S_SDATA(oI2S_SDATA),
		.oMidiRd(oMidiRd), .oMidiVd(oMidiVd)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #(clkPeriod / 2) iCLK = ~iCLK;
	end

	//------------------------------------------------------------
	// Monitors
	//------------------------------------------------------------
	// Every received byte, in arrival order
	always @(posedge iCLK)
	begin
		if (rstN && oMidiVd)
			rxQ.push_back(oMidiRd);
	end

	// I2S capture; an LRCLK change means the previous slot's LSB just arrived
	always @(posedge oI2S_BCLK)
	begin
		shiftIn = {shiftIn[14:0], oI2S_SDATA};
		if (oI2S_LRCLK != lrPrev)
		begin
			if (!lrPrev)
			begin
				leftWord = sampleT'(shiftIn);
				frameCnt = frameCnt + 1;
			end
			else
				assert (sampleT'(shiftIn) == leftWord)
				else
				begin
					$display("Fail at %0t: right word %h differs from left word %h",
						$time, shiftIn, leftWord);
					stereoErrs = stereoErrs + 1;
				end
		end
		lrPrev = oI2S_LRCLK;
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge iCLK);
		$display("Timeout: run did not finish within %0d clock cycles", watchdogCycles);
		$display("Checks failed");
		$finish;
	end

	//------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------
	// Keeps the main thread 2 ns past a rising edge
	task automatic waitCycles(input int n);
		repeat (n) @(posedge iCLK);
		#driveDelay;
	endtask

	task automatic setEntry(input int idx, input logic [7:0] st, input noteNumT n,
		input velocityT v, input int amp);
		tabStatus[idx] = st;
		tabNote[idx]   = n;
		tabVel[idx]    = v;
		tabAmp[idx]    = amp;
	endtask

	// 8N1 frame, LSB first, then wait for the echo on oMidiVd
	task automatic sendByte(input logic [7:0] b);
		logic [9:0] frame;
		logic [7:0] got;
		int         waitCnt;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			iMIDI = frame[i];
			waitCycles(`SYN_BAUD_DIV);
		end
		waitCnt = 0;
		while (rxQ.size() == 0 && waitCnt < 4 * `SYN_BAUD_DIV)
		begin
			waitCycles(1);
			waitCnt++;
		end
		if (rxQ.size() == 0)
		begin
			$display("Byte %h was sent but never appeared on oMidiVd (time %0t)", b, $time);
			errCount++;
		end
		else
		begin
			got = rxQ.pop_front();
			assert (got == b)
			else
			begin
				$display("Fail at %0t: echoed byte %h, expected %h", $time, got, b);
				errCount++;
			end
		end
	endtask

	// Skip two frames, then every left word must be 0 or +/-amp with both signs
	task automatic checkTone(input int amp, input int note);
		sampleT s;
		bit     seenPos;
		bit     seenNeg;
		int     limit;
		seenPos = 1'b0;
		seenNeg = 1'b0;
		limit   = (amp == 0) ? 4 : (note + 3) * 2;
		repeat (2) @(frameCnt);
		for (int i = 0; i < limit; i++)
		begin
			@(frameCnt);
			s = leftWord;
			if (amp == 0)
				assert (s == '0)
				else
				begin
					$display("Fail at %0t: sample %0d, expected silence", $time, s);
					errCount++;
				end
			else
				assert (s == sampleT'(amp) || s == -sampleT'(amp))
				else
				begin
					$display("Fail at %0t: sample %0d, expected +/-%0d", $time, s, amp);
					errCount++;
				end
			if (amp != 0 && s == sampleT'(amp))
				seenPos = 1'b1;
			if (amp != 0 && s == -sampleT'(amp))
				seenNeg = 1'b1;
			if (seenPos && seenNeg)
				break;
		end
		if (amp != 0)
			assert (seenPos && seenNeg)
			else
			begin
				$display("Fail at %0t: tone did not change sign within %0d frames",
					$time, limit);
				errCount++;
			end
		waitCycles(1);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------
	initial
	begin
		noteNumT noteA;
		noteNumT noteB;
		noteNumT toneNote;
		int      errBefore;
		void'($urandom(54));
		noteA    = noteNumT'($urandom % (noteMax + 1));
		noteB    = noteNumT'($urandom % (noteMax + 1));
		toneNote = '0;
		// Note-on, release, CC and foreign note-off, then 9x velocity 0
		setEntry(0, 8'h90, noteA, 7'd100, 100 << `SYN_AMP_SHIFT);
		setEntry(1, 8'h80, noteA, 7'd64, 0);
		setEntry(2, 8'h93, noteB, 7'd20, 20 << `SYN_AMP_SHIFT);
		setEntry(3, 8'hB0, 7'd7, 7'd99, 20 << `SYN_AMP_SHIFT);
		setEntry(4, 8'h80, noteNumT'((noteB + 1) % (noteMax + 1)), 7'd64,
			20 << `SYN_AMP_SHIFT);
		setEntry(5, 8'h9F, noteB, 7'd0, 0);
		setEntry(6, 8'h95, noteA, 7'd127, 127 << `SYN_AMP_SHIFT);
		setEntry(7, 8'h92, noteA, 7'd0, 0);

		iMIDI = 1'b1;
		rstN  = 1'b0;
		waitCycles(10);
		rstN = 1'b1;

		// Silence straight out of reset
		errBefore = errCount;
		checkTone(0, 0);
		if (errCount != errBefore)
			testsFailed++;
		$display("Test reset silence: %s", (errCount == errBefore) ? "ok" : "FAIL");

		for (int e = 0; e < numEntries; e++)
		begin
			errBefore = errCount;
			sendByte(tabStatus[e]);
			sendByte({1'b0, tabNote[e]});
			sendByte({1'b0, tabVel[e]});
			if (tabStatus[e][7:4] == 4'h9 && tabVel[e] != 7'd0)
				toneNote = tabNote[e];
			checkTone(tabAmp[e], int'(toneNote));
			if (errCount != errBefore)
				testsFailed++;
			$display("Test %0d msg %h %h %h amp %0d: %s", e, tabStatus[e], tabNote[e],
				tabVel[e], tabAmp[e], (errCount == errBefore) ? "ok" : "FAIL");
		end

		assert (rxQ.size() == 0)
		else
		begin
			$display("Extra bytes appeared on oMidiVd: %0d", rxQ.size());
			errCount++;
		end
		errCount = errCount + stereoErrs;
		$display("Tests run: %0d, tests failed: %0d, check errors: %0d",
			numEntries + 1, testsFailed, errCount);
		if (errCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+src
src/synthPkg.sv
src/noteIf.sv
src/bitTimer.sv
src/midiRx.sv
src/midiParser.sv
src/toneOsc.sv
src/i2sTx.sv
src/synthBlock.sv
testbench/tbSynth.sv

// File: run.sh
#!/bin/sh
# Compile and run the tone generator testbench with Verilator
set -e

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tbSynth -f tb.f -o simTbSynth

out=$(./obj_dir/simTbSynth)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
